// File: exec_config.svh
// Execute pipeline configuration.
// Word width and instruction immediate field widths.
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath width.
`define WORD_W 16

// Immediate fields carried in the instruction word.
`define IMM5_W 5
`define IMM8_W 8
`define IMM11_W 11

`endif

// File: isaPkg.sv
// Instruction set definitions for the 16-bit teaching processor.
// Opcodes, R-format function codes and the decoded views of one instruction word.
`default_nettype none
`include "exec_config.svh"

package isaPkg;

   //////////////////////////////
   // Opcodes
   //////////////////////////////
   typedef enum logic [4:0] {
      OP_J     = 5'b00100, // PC relative jump.
      OP_JR    = 5'b00101, // Register relative jump.
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001, // Imm minus Rs.
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_BEQZ  = 5'b01100,
      OP_BNEZ  = 5'b01101,
      OP_BLTZ  = 5'b01110,
      OP_BGEZ  = 5'b01111,
      OP_SLBI  = 5'b10010, // Shift left and load byte.
      OP_BTR   = 5'b11001, // Bit reverse.
      OP_RTYPE = 5'b11011, // ADD, SUB, XOR, ANDN by func.
      OP_SEQ   = 5'b11100,
      OP_SLT   = 5'b11101,
      OP_SLE   = 5'b11110,
      OP_SCO   = 5'b11111  // Set on carry out.
   } opcode_e;

   // ALU functions.
   typedef enum logic [1:0] {
      ALU_ADD  = 2'b00, // Sum with carry in.
      ALU_XOR  = 2'b01,
      ALU_ANDN = 2'b10, // AND of conditioned operands.
      ALU_PASS = 2'b11  // Conditioned B operand.
   } aluOp_e;

   // R-format function field.
   localparam logic [1:0] FN_ADD  = 2'b00;
   localparam logic [1:0] FN_SUB  = 2'b01;
   localparam logic [1:0] FN_XOR  = 2'b10;
   localparam logic [1:0] FN_ANDN = 2'b11;

   //////////////////////////////
   // Instruction formats
   //////////////////////////////
   typedef struct packed {
      opcode_e    opcode;
      logic [2:0] rs;
      logic [2:0] rt;
      logic [2:0] rd;
      logic [1:0] func;
   } rFmt_s;

   typedef struct packed {
      opcode_e                opcode;
      logic [2:0]             rs;
      logic [2:0]             rd;
      logic [`IMM5_W-1:0]     imm5;
   } iFmt_s;

   typedef struct packed {
      opcode_e                opcode;
      logic [`IMM11_W-1:0]    imm11; // Branch offset is the low byte.
   } jFmt_s;

   typedef union packed {
      rFmt_s rFmt;
      iFmt_s iFmt;
      jFmt_s jFmt;
   } instrWord_u;

endpackage

`default_nettype wire

// File: pipePkg.sv
// Pipeline stage payloads for the execute pipeline.
// Input bundle, decoded bundle between stages and the output bundle.
`default_nettype none
`include "exec_config.svh"

package pipePkg;

   // Into the decode stage.
   typedef struct packed {
      isaPkg::instrWord_u    instr;
      logic [`WORD_W-1:0]    pc;   // Already incremented.
      logic [`WORD_W-1:0]    aVal; // Rs read value.
      logic [`WORD_W-1:0]    bVal; // Rt read value.
   } execIn_s;

   // Decode stage to execute stage.
   typedef struct packed {
      isaPkg::opcode_e       opcode;
      isaPkg::aluOp_e        aluOp;
      logic                  invA;
      logic                  invB;
      logic                  cin;
      logic [`WORD_W-1:0]    aVal;
      logic [`WORD_W-1:0]    bOper;    // Selected B operand.
      logic [`WORD_W-1:0]    brOffset; // Sign extended jump or branch offset.
      logic [`WORD_W-1:0]    pc;
      logic                  isJump;    // J.
      logic                  isJumpReg; // JR.
   } decoded_s;

   // Out of the execute stage.
   typedef struct packed {
      logic [`WORD_W-1:0]    result;
      logic [`WORD_W-1:0]    newPC;
   } execOut_s;

endpackage

`default_nettype wire

// File: alu.sv
// Adder based ALU with operand inversion.
// Add, xor, andn and pass, with zero, sign, overflow and carry out flags.
`timescale 1ns/10ps
`default_nettype none
`include "exec_config.svh"

module alu (
   input  wire [`WORD_W-1:0]   a,
   input  wire [`WORD_W-1:0]   b,
   input  wire                 invA,
   input  wire                 invB,
   input  wire                 cin,
   input  wire isaPkg::aluOp_e aluOp,
   output logic [`WORD_W-1:0]  out,
   output logic                zero,
   output logic                sign,
   output logic                ofl,
   output logic                cout
);

   logic [`WORD_W-1:0] aa;    // Conditioned A.
   logic [`WORD_W-1:0] bb;    // Conditioned B.
   logic [`WORD_W-1:0] sum;
   logic               carry;

   assign aa = invA ? ~a : a;
   assign bb = invB ? ~b : b;

   // One adder serves ADD, SUB and the compares.
   assign {carry, sum} = {1'b0, aa} + {1'b0, bb} + {{`WORD_W{1'b0}}, cin};

   always_comb begin
      case (aluOp)
         isaPkg::ALU_ADD:  out = sum;
         isaPkg::ALU_XOR:  out = aa ^ bb;
         isaPkg::ALU_ANDN: out = aa & bb; // Inverted B comes in via invB.
         isaPkg::ALU_PASS: out = bb;
         default:          out = sum;
      endcase
   end

   //////////////////////////////
   // Flags
   //////////////////////////////
   assign zero = (out == '0);
   assign sign = out[`WORD_W-1];
   assign cout = carry;

   // Same sign operands giving a result of the other sign.
   assign ofl  = (aa[`WORD_W-1] == bb[`WORD_W-1]) & (sum[`WORD_W-1] != aa[`WORD_W-1]);

endmodule

`default_nettype wire

// File: decodeStage.sv
// Decode stage of the execute pipeline.
// Maps the opcode to ALU controls, picks the B operand and offset, then registers them.
`timescale 1ns/10ps
`default_nettype none
`include "exec_config.svh"

module decodeStage (
   input  wire                     clk,
   input  wire                     rstN,
   input  wire pipePkg::execIn_s   inData,
   input  wire                     inValid,
   output logic                    inReady,
   output pipePkg::decoded_s       decodedData,
   output logic                    decValid,
   input  wire                     execReady
);

   isaPkg::instrWord_u   instr;   // Decoded views of the word.
   pipePkg::decoded_s    decNext; // Next slot contents.
   logic [`WORD_W-1:0]   sImm5;   // Sign extended imm5.
   logic [`WORD_W-1:0]   zImm5;   // Zero extended imm5.
   logic [`WORD_W-1:0]   sImm8;   // Sign extended low byte.
   logic [`WORD_W-1:0]   sImm11;  // Sign extended imm11.
   logic [`WORD_W-1:0]   slbiVal; // Rs shifted by 8 with the byte below.
   logic [`IMM8_W-1:0]   imm8;

   assign instr   = inData.instr;
   assign imm8    = instr.jFmt.imm11[`IMM8_W-1:0];
   assign sImm5   = {{(`WORD_W-`IMM5_W){instr.iFmt.imm5[`IMM5_W-1]}}, instr.iFmt.imm5};
   assign zImm5   = {{(`WORD_W-`IMM5_W){1'b0}}, instr.iFmt.imm5};
   assign sImm8   = {{(`WORD_W-`IMM8_W){imm8[`IMM8_W-1]}}, imm8};
   assign sImm11  = {{(`WORD_W-`IMM11_W){instr.jFmt.imm11[`IMM11_W-1]}}, instr.jFmt.imm11};
   assign slbiVal = {inData.aVal[`WORD_W-`IMM8_W-1:0], imm8};

   //////////////////////////////
   // Control decode
   //////////////////////////////
   always_comb begin
      decNext           = '0;
      decNext.opcode    = instr.rFmt.opcode;
      decNext.aluOp     = isaPkg::ALU_ADD; // Unknown opcodes run as ADD.
      decNext.aVal      = inData.aVal;
      decNext.bOper     = inData.bVal;
      decNext.brOffset  = sImm8;           // Branches and JR.
      decNext.pc        = inData.pc;
      case (instr.rFmt.opcode)
         isaPkg::OP_RTYPE: begin
            case (instr.rFmt.func)
               isaPkg::FN_ADD: decNext.aluOp = isaPkg::ALU_ADD;
               isaPkg::FN_SUB: begin
                  decNext.invA = 1'b1; // Rt minus Rs.
                  decNext.cin  = 1'b1;
               end
               isaPkg::FN_XOR: decNext.aluOp = isaPkg::ALU_XOR;
               isaPkg::FN_ANDN: begin
                  decNext.aluOp = isaPkg::ALU_ANDN;
                  decNext.invB  = 1'b1;
               end
               default: decNext.aluOp = isaPkg::ALU_ADD;
            endcase
         end
         isaPkg::OP_ADDI: decNext.bOper = sImm5;
         isaPkg::OP_SUBI: begin
            decNext.bOper = sImm5;
            decNext.invA  = 1'b1;
            decNext.cin   = 1'b1;
         end
         isaPkg::OP_XORI: begin
            decNext.aluOp = isaPkg::ALU_XOR;
            decNext.bOper = zImm5;
         end
         isaPkg::OP_ANDNI: begin
            decNext.aluOp = isaPkg::ALU_ANDN;
            decNext.invB  = 1'b1;
            decNext.bOper = zImm5;
         end
         isaPkg::OP_SLBI: begin
            decNext.aluOp = isaPkg::ALU_PASS;
            decNext.bOper = slbiVal;
         end
         isaPkg::OP_SEQ, isaPkg::OP_SLT, isaPkg::OP_SLE: begin
            decNext.invA = 1'b1; // Rt minus Rs for the compares.
            decNext.cin  = 1'b1;
         end
         isaPkg::OP_BTR, isaPkg::OP_BEQZ, isaPkg::OP_BNEZ,
         isaPkg::OP_BLTZ, isaPkg::OP_BGEZ: begin
            decNext.bOper = '0; // ALU passes Rs so flags test it.
         end
         isaPkg::OP_J: begin
            decNext.bOper    = '0;
            decNext.brOffset = sImm11;
            decNext.isJump   = 1'b1;
         end
         isaPkg::OP_JR: begin
            decNext.bOper     = '0;
            decNext.isJumpReg = 1'b1;
         end
         default: ; // SCO and unknown use the plain add.
      endcase
   end

   //////////////////////////////
   // Stage register
   //////////////////////////////
   assign inReady = ~decValid | execReady; // Empty slot always accepts.

   always_ff @(posedge clk) begin
      if (!rstN) begin
         decValid <= 1'b0;
      end else if (inReady) begin
         decValid <= inValid;
      end
   end

   always_ff @(posedge clk) begin
      if (inValid && inReady) begin
         decodedData <= decNext; // Payload loads on transfer only.
      end
   end

endmodule

`default_nettype wire

// File: executeStage.sv
// Execute stage of the pipeline.
// Runs the ALU, forms the set, reverse and ALU results, resolves branches and the next PC.
`timescale 1ns/10ps
`default_nettype none
`include "exec_config.svh"

module executeStage (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire pipePkg::decoded_s   decodedData,
   input  wire                      decValid,
   output logic                     execReady,
   output pipePkg::execOut_s        outData,
   output logic                     outValid,
   input  wire                      outReady
);

   logic [`WORD_W-1:0] aluOut;
   logic               zero, sign, ofl, cout;
   logic               less;     // Signed negative after overflow fix.
   logic               brTaken;  // Conditional branch outcome.
   logic [`WORD_W-1:0] jumpBase; // PC or Rs.
   logic [`WORD_W-1:0] target;
   logic [`WORD_W-1:0] pcNext;   // Selected next PC.
   pipePkg::execOut_s  outNext;

   alu alu0 (
      .a     (decodedData.aVal),
      .b     (decodedData.bOper),
      .invA  (decodedData.invA),
      .invB  (decodedData.invB),
      .cin   (decodedData.cin),
      .aluOp (decodedData.aluOp),
      .out   (aluOut),
      .zero  (zero),
      .sign  (sign),
      .ofl   (ofl),
      .cout  (cout)
   );

   assign less = sign ^ ofl;

   //////////////////////////////
   // Result word
   //////////////////////////////
   always_comb begin
      outNext.newPC = pcNext;
      case (decodedData.opcode)
         isaPkg::OP_SEQ: outNext.result = {{(`WORD_W-1){1'b0}}, zero};
         isaPkg::OP_SLT: outNext.result = {{(`WORD_W-1){1'b0}}, less};
         isaPkg::OP_SLE: outNext.result = {{(`WORD_W-1){1'b0}}, less | zero};
         isaPkg::OP_SCO: outNext.result = {{(`WORD_W-1){1'b0}}, cout}; // Carry of Rs + Rt.
         isaPkg::OP_BTR: begin
            for (int i = 0; i < `WORD_W; i++) begin
               outNext.result[i] = decodedData.aVal[`WORD_W-1-i];
            end
         end
         default:        outNext.result = aluOut;
      endcase
   end

   //////////////////////////////
   // Next PC
   //////////////////////////////
   always_comb begin
      case (decodedData.opcode)
         isaPkg::OP_BEQZ: brTaken = zero;  // ALU output is Rs here.
         isaPkg::OP_BNEZ: brTaken = ~zero;
         isaPkg::OP_BLTZ: brTaken = sign;
         isaPkg::OP_BGEZ: brTaken = ~sign;
         default:         brTaken = 1'b0;
      endcase
   end

   assign jumpBase = decodedData.isJumpReg ? decodedData.aVal : decodedData.pc;
   assign target   = jumpBase + decodedData.brOffset;
   assign pcNext   = (decodedData.isJump | decodedData.isJumpReg | brTaken) ?
                     target : decodedData.pc;

   //////////////////////////////
   // Stage register
   //////////////////////////////
   assign execReady = ~outValid | outReady;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         outValid <= 1'b0;
      end else if (execReady) begin
         outValid <= decValid;
      end
   end

   always_ff @(posedge clk) begin
      if (decValid && execReady) begin
         outData <= outNext;
      end
   end

endmodule

`default_nettype wire

// File: execPipe.sv
// Execute pipeline top level.
// Decode slot followed by execute slot, valid/ready on both ends.
`timescale 1ns/10ps
`default_nettype none

module execPipe (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire pipePkg::execIn_s    inData,
   input  wire                      inValid,
   output logic                     inReady,
   output pipePkg::execOut_s        outData,
   output logic                     outValid,
   input  wire                      outReady
);

   pipePkg::decoded_s decodedData; // Between stages.
   logic              decValid;
   logic              execReady;

   decodeStage decode0 (
      .clk         (clk),
      .rstN        (rstN),
      .inData      (inData),
      .inValid     (inValid),
      .inReady     (inReady),
      .decodedData (decodedData),
      .decValid    (decValid),
      .execReady   (execReady)
   );

   executeStage execute0 (
      .clk         (clk),
      .rstN        (rstN),
      .decodedData (decodedData),
      .decValid    (decValid),
      .execReady   (execReady),
      .outData     (outData),
      .outValid    (outValid),
      .outReady    (outReady)
   );

endmodule

`default_nettype wire

// File: tbClock.sv
// Testbench clock and reset generator.
// 20 ns clock, reset held low for the first 5 cycles.
`timescale 1ns/10ps
`default_nettype none

module tbClock (
   output logic clk,
   output logic rstN
);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk; // 20 ns period.
   end

   initial begin
      rstN = 1'b0;
      repeat (5) @(posedge clk);
      #1 rstN = 1'b1; // Released just after the 5th edge.
   end

endmodule

`default_nettype wire

// File: execPipe_tb.sv
// Testbench for the execute pipeline.
// Replays vectors from exec_input.txt, first with outReady high, then under random back-pressure.
`timescale 1ns/10ps
`default_nettype none
`include "exec_config.svh"

module execPipe_tb;

   localparam int maxWait = 200; // Cycles allowed per wait.

   logic              clk;
   logic              rstN;
   pipePkg::execIn_s  inData;
   logic              inValid;
   logic              inReady;
   pipePkg::execOut_s outData;
   logic              outValid;
   logic              outReady;

   pipePkg::execIn_s  vecIn[$];     // Stimulus per line.
   pipePkg::execOut_s vecExp[$];    // Expected result and newPC.
   int                sentCycle[$]; // Acceptance cycle, in send order.
   int                cycle = 0;
   int                resultErrs = 0;
   int                newPCErrs = 0;
   int                otherErrs = 0;
   logic              rxDone;
   logic [31:0]       seed;

   tbClock clkGen0 (.clk(clk), .rstN(rstN));

   execPipe dut0 (
      .clk      (clk),
      .rstN     (rstN),
      .inData   (inData),
      .inValid  (inValid),
      .inReady  (inReady),
      .outData  (outData),
      .outValid (outValid),
      .outReady (outReady)
   );

   always @(posedge clk) cycle <= cycle + 1; // Sampled at negedge only.

   function automatic logic [31:0] lcgNext(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic checkResult(input pipePkg::execOut_s got, input pipePkg::execOut_s exp,
                              input int idx);
      if (got.result !== exp.result) begin
         $display("[ERROR] vector %0d outData.result got %h expected %h",
                  idx, got.result, exp.result);
         resultErrs++;
      end
   endtask

   task automatic checkNewPC(input pipePkg::execOut_s got, input pipePkg::execOut_s exp,
                             input int idx);
      if (got.newPC !== exp.newPC) begin
         $display("[ERROR] vector %0d outData.newPC got %h expected %h",
                  idx, got.newPC, exp.newPC);
         newPCErrs++;
      end
   endtask

   //////////////////////////////
   // Vector file
   //////////////////////////////
   task automatic loadVectors();
      int                fd;
      int                code;
      logic [`WORD_W-1:0] instrW, pcW, aW, bW, resW, npcW;
      pipePkg::execIn_s  inVec;
      pipePkg::execOut_s expVec;
      fd = $fopen("exec_input.txt", "r");
      if (fd == 0) begin
         $display("Could not open exec_input.txt");
         otherErrs++;
      end else begin
         code = 6;
         while (code == 6 && !$feof(fd)) begin
            code = $fscanf(fd, "%h %h %h %h %h %h\n", instrW, pcW, aW, bW, resW, npcW);
            if (code == 6) begin
               inVec  = {instrW, pcW, aW, bW};
               expVec = {resW, npcW};
               vecIn.push_back(inVec);
               vecExp.push_back(expVec);
            end
         end
         $fclose(fd);
         if (vecIn.size() == 0) begin
            $display("No vectors found in exec_input.txt");
            otherErrs++;
         end
      end
   endtask

   //////////////////////////////
   // Handshake tasks
   //////////////////////////////
   task automatic waitReset();
      int waits;
      waits = 0;
      @(posedge clk);
      while (!rstN && waits < maxWait) begin
         @(posedge clk);
         waits++;
      end
      if (!rstN) begin
         $display("Timeout: reset was never released");
         otherErrs++;
      end
      @(negedge clk); // Idle state before any input.
      if (outValid !== 1'b0) begin
         $display("[ERROR] outValid got %h expected %h after reset", outValid, 1'b0);
         otherErrs++;
      end
      if (inReady !== 1'b1) begin
         $display("[ERROR] inReady got %h expected %h after reset", inReady, 1'b1);
         otherErrs++;
      end
   endtask

   task automatic sendVectors();
      int   waits;
      logic taken;
      sentCycle.delete();
      @(posedge clk);
      #1;
      for (int i = 0; i < vecIn.size(); i++) begin
         inData  = vecIn[i];
         inValid = 1'b1;
         waits   = 0;
         taken   = 1'b0;
         while (!taken && waits < maxWait) begin
            @(negedge clk);
            taken = inReady; // Transfer on the coming edge.
            if (taken) sentCycle.push_back(cycle);
            @(posedge clk);
            #1;
            waits++;
         end
         if (!taken) begin
            $display("Timeout: inReady stayed low for vector %0d", i);
            otherErrs++;
            break;
         end
      end
      inValid = 1'b0;
   endtask

   task automatic collectVectors(input logic checkLatency);
      int   waits;
      logic got;
      for (int j = 0; j < vecExp.size(); j++) begin
         waits = 0;
         got   = 1'b0;
         while (!got && waits < maxWait) begin
            @(negedge clk);
            got = outValid && outReady;
            waits++;
         end
         if (!got) begin
            $display("Timeout: no output for vector %0d", j);
            otherErrs++;
            break;
         end
         checkResult(outData, vecExp[j], j);
         checkNewPC(outData, vecExp[j], j);
         if (checkLatency && cycle - sentCycle[j] != 2) begin
            $display("Vector %0d came out %0d cycles after it was accepted instead of 2",
                     j, cycle - sentCycle[j]);
            otherErrs++;
         end
         if (checkLatency && j > 0 && sentCycle[j] - sentCycle[j-1] != 1) begin
            $display("Vector %0d was accepted %0d cycles after the one before instead of 1",
                     j, sentCycle[j] - sentCycle[j-1]);
            otherErrs++;
         end
      end
      rxDone = 1'b1;
   endtask

   task automatic toggleReady();
      for (int k = 0; k < maxWait * vecExp.size() && !rxDone; k++) begin
         @(posedge clk);
         #1;
         seed     = lcgNext(seed);
         outReady = seed[28];
      end
      outReady = 1'b1;
   endtask

   task automatic expectDrained();
      @(negedge clk); // One edge after the last transfer.
      if (outValid !== 1'b0) begin
         $display("[ERROR] outValid got %h expected %h after the last vector", outValid, 1'b0);
         otherErrs++;
      end
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial begin
      inData   = '0;
      inValid  = 1'b0;
      outReady = 1'b1;
      rxDone   = 1'b0;
      seed     = 32'h8854e21f;
      loadVectors();
      waitReset();
      if (otherErrs == 0) begin
         fork // Full rate, latency checked.
            sendVectors();
            collectVectors(1'b1);
         join
         expectDrained();
         rxDone = 1'b0;
         fork // Random back-pressure, order checked.
            sendVectors();
            collectVectors(1'b0);
            toggleReady();
         join
         expectDrained();
      end
      $display("Errors: result %0d, newPC %0d, other %0d", resultErrs, newPCErrs, otherErrs);
      if (resultErrs + newPCErrs + otherErrs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
isaPkg.sv
pipePkg.sv
alu.sv
decodeStage.sv
executeStage.sv
execPipe.sv
tbClock.sv
execPipe_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the execute pipeline testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --timescale 1ns/10ps -f filelist.f \
   --top-module execPipe_tb --Mdir "$OBJ" -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/simv" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The log decides the outcome.
if grep -q "Testbench failed" "$LOG"; then
   exit 1
fi
exit 0

// File: exec_input.txt
D94C 0102 1234 4321 5555 0102
D94D 0104 1000 0234 F234 0104
D94E 0106 F0F0 0FF0 FF00 0106
D94F 0108 FFFF 0F0F F0F0 0108
415C 010A 0010 BEEF 000C 010A
4943 010C 0005 BEEF FFFE 010C
515F 010E 8001 BEEF 801E 010E
5950 0110 00FF BEEF 00EF 0110
91A5 0112 1234 BEEF 34A5 0112
E14C 0114 7777 7777 0001 0114
E94C 0116 7FFF 8000 0001 0116
E94C 0118 0003 0005 0000 0118
F14C 011A 8000 7FFF 0000 011A
F14C 011C FFF0 FFF0 0001 011C
F94C 011E FFFF 0001 0001 011E
F94C 0120 1234 0001 0000 0120
C90C 0122 1234 5A5A 2C48 0122
6110 0124 0000 5A5A 0000 0134
69F0 0126 0000 5A5A 0000 0126
71F0 0128 8000 5A5A 8000 0118
7908 012A FFFF 5A5A FFFF 012A
7908 012C 0005 5A5A 0005 0134
27FE 012E 0042 5A5A 0042 012C
2904 0130 2000 5A5A 2000 2004
014C 0132 0001 0002 0003 0132
